// ==== design/sb_pkg.sv ====
/*
 * shared widths, register and data types and the functional unit encoding
 * for the issue scoreboard, imported by every design module
 */
package sb_pkg;

  // ----------------------------------------
  // register file geometry
  // ----------------------------------------
  // 5 bit register address, 32 integer registers
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NR_REGS    = 2 ** REG_ADDR_W;

  // data path width
  localparam int unsigned XLEN = 32;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [XLEN-1:0]       xlen_t;

  // ----------------------------------------
  // functional units
  // ----------------------------------------
  // in a table entry FU_NONE means the instruction completes on its own,
  // in the clobber map it means no pending writer for that register
  typedef enum logic [2:0] {
    FU_NONE   = 3'd0,
    FU_ALU    = 3'd1,
    FU_LOAD   = 3'd2,
    FU_STORE  = 3'd3,
    FU_MULT   = 3'd4,
    FU_BRANCH = 3'd5
  } fu_e;

  // codes 6 and 7 are unused

endpackage

// ==== design/sb_entry_table.sv ====
/*
 * circular table of in-flight instructions with issue and commit pointers;
 * slot index doubles as trans ID, exports per-slot state to the side units
 */
`timescale 1ns/1ns

module sb_entry_table import sb_pkg::*; #(
  parameter int unsigned NrEntries = 8,
  parameter int unsigned NrWbPorts = 2,
  localparam int unsigned TransIdW = $clog2(NrEntries)
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 flush_i,
  input  logic                                 flush_unissued_i,
  input  logic                                 unresolved_branch_i,
  output logic                                 sb_full_o,
  // decode and issue side
  input  logic                                 decoded_valid_i,
  input  fu_e                                  decoded_fu_i,
  input  reg_addr_t                            decoded_rd_i,
  output logic                                 decoded_ack_o,
  output logic                                 issue_valid_o,
  input  logic                                 issue_ack_i,
  output logic [TransIdW-1:0]                  issue_trans_id_o,
  // write-back ports
  input  logic [NrWbPorts-1:0]                 wb_valid_i,
  input  logic [NrWbPorts-1:0][TransIdW-1:0]   wb_trans_id_i,
  input  xlen_t [NrWbPorts-1:0]                wb_data_i,
  // commit port
  output logic                                 commit_valid_o,
  input  logic                                 commit_ack_i,
  output fu_e                                  commit_fu_o,
  output reg_addr_t                            commit_rd_o,
  output xlen_t                                commit_result_o,
  output logic [TransIdW-1:0]                  commit_trans_id_o,
  // per-slot state for clobber map and forwarder
  output logic [NrEntries-1:0]                 entry_issued_o,
  output logic [NrEntries-1:0]                 entry_done_o,
  output reg_addr_t [NrEntries-1:0]            entry_rd_o,
  output fu_e [NrEntries-1:0]                  entry_fu_o,
  output xlen_t [NrEntries-1:0]                entry_result_o
);

  // control state per slot
  logic [NrEntries-1:0]    issued_q, issued_n;
  logic [NrEntries-1:0]    done_q, done_n;
  // payload per slot
  fu_e [NrEntries-1:0]       fu_q, fu_n;
  reg_addr_t [NrEntries-1:0] rd_q, rd_n;
  xlen_t [NrEntries-1:0]     result_q, result_n;

  logic [TransIdW-1:0] issue_ptr_q, issue_ptr_n;
  logic [TransIdW-1:0] commit_ptr_q, commit_ptr_n;
  // one bit wider than a pointer, msb set means all slots taken
  logic [TransIdW:0]   cnt_q, cnt_n;
  logic                full;
  logic                issue_en;

  // only valid because NrEntries is a power of two
  assign full      = cnt_q[TransIdW];
  assign sb_full_o = full;

  // no same-cycle bypass, a commit frees the slot for the next cycle
  assign issue_valid_o    = decoded_valid_i & ~unresolved_branch_i & ~full;
  assign decoded_ack_o    = issue_ack_i & ~full;
  assign issue_trans_id_o = issue_ptr_q;
  assign issue_en         = decoded_valid_i & decoded_ack_o & ~flush_unissued_i;

  // oldest entry straight to commit
  assign commit_valid_o    = issued_q[commit_ptr_q] & done_q[commit_ptr_q];
  assign commit_fu_o       = fu_q[commit_ptr_q];
  assign commit_rd_o       = rd_q[commit_ptr_q];
  assign commit_result_o   = result_q[commit_ptr_q];
  assign commit_trans_id_o = commit_ptr_q;

  assign entry_issued_o = issued_q;
  assign entry_done_o   = done_q;
  assign entry_rd_o     = rd_q;
  assign entry_fu_o     = fu_q;
  assign entry_result_o = result_q;

  // ----------------------------------------
  // slot update, later steps override earlier
  // ----------------------------------------
  always_comb begin : slot_update
    issued_n = issued_q;
    done_n   = done_q;
    fu_n     = fu_q;
    rd_n     = rd_q;
    result_n = result_q;
    // new instruction at the issue pointer
    if (issue_en) begin
      issued_n[issue_ptr_q] = 1'b1;
      done_n[issue_ptr_q]   = 1'b0;
      fu_n[issue_ptr_q]     = decoded_fu_i;
      rd_n[issue_ptr_q]     = decoded_rd_i;
      result_n[issue_ptr_q] = '0;
    end
    // no unit behind it, complete one edge after the write
    for (int unsigned i = 0; i < NrEntries; i++) begin
      if (issued_q[i] && fu_q[i] == FU_NONE) begin
        done_n[i] = 1'b1;
      end
    end
    // results only land in issued slots, stale ones after a flush are dropped
    for (int unsigned k = 0; k < NrWbPorts; k++) begin
      if (wb_valid_i[k] && issued_q[wb_trans_id_i[k]]) begin
        done_n[wb_trans_id_i[k]]   = 1'b1;
        result_n[wb_trans_id_i[k]] = wb_data_i[k];
      end
    end
    // retire the oldest slot
    if (commit_ack_i) begin
      issued_n[commit_ptr_q] = 1'b0;
      done_n[commit_ptr_q]   = 1'b0;
    end
    if (flush_i) begin
      issued_n = '0;
      done_n   = '0;
    end
  end

  // pointer and occupancy
  assign cnt_n = flush_i ? '0 :
                 cnt_q - (TransIdW + 1)'(commit_ack_i) + (TransIdW + 1)'(issue_en);
  assign issue_ptr_n  = flush_i ? '0 : issue_ptr_q + TransIdW'(issue_en);
  assign commit_ptr_n = flush_i ? '0 : commit_ptr_q + TransIdW'(commit_ack_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
    if (!rst_ni) begin
      issued_q     <= '0;
      done_q       <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      issued_q     <= issued_n;
      done_q       <= done_n;
      issue_ptr_q  <= issue_ptr_n;
      commit_ptr_q <= commit_ptr_n;
      cnt_q        <= cnt_n;
    end
  end

  // payload is qualified by issued everywhere it is read
  always_ff @(posedge clk_i) begin : payload_regs
    fu_q     <= fu_n;
    rd_q     <= rd_n;
    result_q <= result_n;
  end

endmodule

// ==== design/sb_clobber_map.sv ====
/*
 * per-register view of the unit that will write it next, taken from the
 * issued slots; feeds the issue stage hazard check
 */
`timescale 1ns/1ns

module sb_clobber_map import sb_pkg::*; #(
  parameter int unsigned NrEntries = 8
) (
  input  logic [NrEntries-1:0]      entry_issued_i,
  input  reg_addr_t [NrEntries-1:0] entry_rd_i,
  input  fu_e [NrEntries-1:0]       entry_fu_i,
  output fu_e [NR_REGS-1:0]         rd_clobber_o
);

  // one request per register and slot
  logic [NR_REGS-1:0][NrEntries-1:0] clobber_vld;

  // ----------------------------------------
  // destination decode
  // ----------------------------------------
  always_comb begin : clobber_decode
    clobber_vld = '0;
    for (int unsigned i = 0; i < NrEntries; i++) begin
      clobber_vld[entry_rd_i[i]][i] = entry_issued_i[i];
    end
    // x0 is never clobbered
    clobber_vld[0] = '0;
  end

  // ----------------------------------------
  // fixed priority select per register
  // ----------------------------------------
  always_comb begin : clobber_select
    for (int unsigned r = 0; r < NR_REGS; r++) begin
      // default when no slot requests
      rd_clobber_o[r] = FU_NONE;
      // walk down so the lowest slot index is applied last and wins
      for (int i = NrEntries - 1; i >= 0; i--) begin
        if (clobber_vld[r][i]) begin
          rd_clobber_o[r] = entry_fu_i[i];
        end
      end
    end
  end

endmodule

// ==== design/sb_operand_forward.sv ====
/*
 * operand forwarding for two read ports, write-back data first and then
 * completed slots in index order; gives valid only for a nonzero address
 */
`timescale 1ns/1ns

module sb_operand_forward import sb_pkg::*; #(
  parameter int unsigned NrEntries = 8,
  parameter int unsigned NrWbPorts = 2,
  localparam int unsigned TransIdW = $clog2(NrEntries)
) (
  input  reg_addr_t                          rs1_i,
  input  reg_addr_t                          rs2_i,
  input  logic [NrWbPorts-1:0]               wb_valid_i,
  input  logic [NrWbPorts-1:0][TransIdW-1:0] wb_trans_id_i,
  input  xlen_t [NrWbPorts-1:0]              wb_data_i,
  input  logic [NrEntries-1:0]               entry_issued_i,
  input  logic [NrEntries-1:0]               entry_done_i,
  input  reg_addr_t [NrEntries-1:0]          entry_rd_i,
  input  xlen_t [NrEntries-1:0]              entry_result_i,
  output xlen_t                              rs1_o,
  output logic                               rs1_valid_o,
  output xlen_t                              rs2_o,
  output logic                               rs2_valid_o
);

  // wb ports sit at the low indices, so they win over slots
  localparam int unsigned NrSrc = NrWbPorts + NrEntries;

  reg_addr_t [1:0]    rs_addr;
  xlen_t [NrSrc-1:0]  src_data;

  assign rs_addr = {rs2_i, rs1_i};

  // ----------------------------------------
  // candidate data, same for both ports
  // ----------------------------------------
  for (genvar k = 0; k < NrWbPorts; k++) begin : gen_wb_src
    assign src_data[k] = wb_data_i[k];
  end
  for (genvar k = 0; k < NrEntries; k++) begin : gen_entry_src
    assign src_data[NrWbPorts+k] = entry_result_i[k];
  end

  // ----------------------------------------
  // per read port request and select
  // ----------------------------------------
  for (genvar p = 0; p < 2; p++) begin : gen_read_port
    logic [NrSrc-1:0] fwd_req;
    xlen_t            sel_data;
    logic             sel_vld;

    always_comb begin : build_req
      // result in flight, matched on the destination of the slot it targets
      for (int unsigned k = 0; k < NrWbPorts; k++) begin
        fwd_req[k] = wb_valid_i[k] & (entry_rd_i[wb_trans_id_i[k]] == rs_addr[p]);
      end
      // result already sitting in a completed slot
      for (int unsigned k = 0; k < NrEntries; k++) begin
        fwd_req[NrWbPorts+k] = entry_issued_i[k] & entry_done_i[k] &
                               (entry_rd_i[k] == rs_addr[p]);
      end
    end

    always_comb begin : select_src
      sel_vld  = 1'b0;
      sel_data = '0;
      // lowest requesting index ends up on top
      for (int i = NrSrc - 1; i >= 0; i--) begin
        if (fwd_req[i]) begin
          sel_vld  = 1'b1;
          sel_data = src_data[i];
        end
      end
    end
  end

  // x0 reads always come from the register file
  assign rs1_o       = gen_read_port[0].sel_data;
  assign rs1_valid_o = gen_read_port[0].sel_vld & (|rs1_i);
  assign rs2_o       = gen_read_port[1].sel_data;
  assign rs2_valid_o = gen_read_port[1].sel_vld & (|rs2_i);

endmodule

// ==== design/scoreboard_top.sv ====
/*
 * issue scoreboard top level; entry table plus the clobber map and the
 * operand forwarder that both work off the table state
 */
`timescale 1ns/1ns

module scoreboard_top import sb_pkg::*; #(
  parameter int unsigned NrEntries = 8,
  parameter int unsigned NrWbPorts = 2,
  localparam int unsigned TransIdW = $clog2(NrEntries)
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               flush_i,
  input  logic                               flush_unissued_i,
  input  logic                               unresolved_branch_i,
  output logic                               sb_full_o,
  // decode and issue
  input  logic                               decoded_valid_i,
  input  fu_e                                decoded_fu_i,
  input  reg_addr_t                          decoded_rd_i,
  output logic                               decoded_ack_o,
  output logic                               issue_valid_o,
  input  logic                               issue_ack_i,
  output logic [TransIdW-1:0]                issue_trans_id_o,
  // write-back
  input  logic [NrWbPorts-1:0]               wb_valid_i,
  input  logic [NrWbPorts-1:0][TransIdW-1:0] wb_trans_id_i,
  input  xlen_t [NrWbPorts-1:0]              wb_data_i,
  // commit
  output logic                               commit_valid_o,
  input  logic                               commit_ack_i,
  output fu_e                                commit_fu_o,
  output reg_addr_t                          commit_rd_o,
  output xlen_t                              commit_result_o,
  output logic [TransIdW-1:0]                commit_trans_id_o,
  // operand read
  input  reg_addr_t                          rs1_i,
  output xlen_t                              rs1_o,
  output logic                               rs1_valid_o,
  input  reg_addr_t                          rs2_i,
  output xlen_t                              rs2_o,
  output logic                               rs2_valid_o,
  // pending writer per register
  output fu_e [NR_REGS-1:0]                  rd_clobber_o
);

  // table state shared by both side units
  logic [NrEntries-1:0]      entry_issued;
  logic [NrEntries-1:0]      entry_done;
  reg_addr_t [NrEntries-1:0] entry_rd;
  fu_e [NrEntries-1:0]       entry_fu;
  xlen_t [NrEntries-1:0]     entry_result;

  sb_entry_table #(
    .NrEntries ( NrEntries ),
    .NrWbPorts ( NrWbPorts )
  ) i_entry_table (
    .clk_i, .rst_ni, .flush_i, .flush_unissued_i, .unresolved_branch_i, .sb_full_o,
    .decoded_valid_i, .decoded_fu_i, .decoded_rd_i, .decoded_ack_o,
    .issue_valid_o, .issue_ack_i, .issue_trans_id_o,
    .wb_valid_i, .wb_trans_id_i, .wb_data_i,
    .commit_valid_o, .commit_ack_i, .commit_fu_o, .commit_rd_o,
    .commit_result_o, .commit_trans_id_o,
    .entry_issued_o ( entry_issued ),
    .entry_done_o   ( entry_done   ),
    .entry_rd_o     ( entry_rd     ),
    .entry_fu_o     ( entry_fu     ),
    .entry_result_o ( entry_result )
  );

  sb_clobber_map #(
    .NrEntries ( NrEntries )
  ) i_clobber_map (
    .entry_issued_i ( entry_issued ),
    .entry_rd_i     ( entry_rd     ),
    .entry_fu_i     ( entry_fu     ),
    .rd_clobber_o
  );

  sb_operand_forward #(
    .NrEntries ( NrEntries ),
    .NrWbPorts ( NrWbPorts )
  ) i_operand_forward (
    .rs1_i, .rs2_i, .wb_valid_i, .wb_trans_id_i, .wb_data_i,
    .entry_issued_i ( entry_issued ),
    .entry_done_i   ( entry_done   ),
    .entry_rd_i     ( entry_rd     ),
    .entry_result_i ( entry_result ),
    .rs1_o, .rs1_valid_o, .rs2_o, .rs2_valid_o
  );

endmodule

// ==== verification/scoreboard_checker.sv ====
/*
 * concurrent protocol checks on the scoreboard ports, bound into the top level
 */
`timescale 1ns/1ns

module scoreboard_checker import sb_pkg::*; (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              commit_valid_o,
  input logic              commit_ack_i,
  input logic              issue_valid_o,
  input logic              issue_ack_i,
  input logic              sb_full_o,
  input logic              decoded_ack_o,
  input fu_e [NR_REGS-1:0] rd_clobber_o
);

  // commit ack only on a valid oldest entry
  a_commit_ack : assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_ack_i |-> commit_valid_o) else $error("commit ack seen without a valid entry");

  // issue ack only while the issue stage is offered something
  a_issue_ack : assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_ack_i |-> issue_valid_o) else $error("issue ack seen without issue valid");

  // x0 never has a pending writer
  a_x0_clobber : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_clobber_o[0] == FU_NONE) else $error("register 0 shows a clobbering unit");

  // full table takes nothing new
  a_full_no_ack : assert property (@(posedge clk_i) disable iff (!rst_ni)
    sb_full_o |-> !decoded_ack_o) else $error("decode acknowledged while table full");

endmodule

bind scoreboard_top scoreboard_checker i_scoreboard_checker (
  .clk_i, .rst_ni, .commit_valid_o, .commit_ack_i, .issue_valid_o, .issue_ack_i,
  .sb_full_o, .decoded_ack_o, .rd_clobber_o
);

// ==== verification/tb_scoreboard.sv ====
/*
 * random testbench for the issue scoreboard; keeps its own slot model and
 * compares every top level output once per cycle on the falling edge
 */
`timescale 1ns/1ns

module tb_scoreboard import sb_pkg::*; ();

  localparam int unsigned NrEntries = 8;
  localparam int unsigned NrWbPorts = 2;
  localparam int unsigned TransIdW  = $clog2(NrEntries);
  typedef logic [TransIdW-1:0] id_t;

  logic                  clk_i, rst_ni, flush_i, flush_unissued_i, unresolved_branch_i;
  logic                  sb_full_o, decoded_valid_i, decoded_ack_o, issue_valid_o, issue_ack_i;
  logic                  commit_valid_o, commit_ack_i, rs1_valid_o, rs2_valid_o;
  fu_e                   decoded_fu_i, commit_fu_o;
  reg_addr_t             decoded_rd_i, commit_rd_o, rs1_i, rs2_i;
  id_t                   issue_trans_id_o, commit_trans_id_o;
  logic [NrWbPorts-1:0]  wb_valid_i;
  id_t [NrWbPorts-1:0]   wb_trans_id_i;
  xlen_t [NrWbPorts-1:0] wb_data_i;
  xlen_t                 commit_result_o, rs1_o, rs2_o;
  fu_e [NR_REGS-1:0]     rd_clobber_o;

  // ----------------------------------------
  // reference model state per slot
  // ----------------------------------------
  logic        m_issued [NrEntries];
  logic        m_done   [NrEntries];
  fu_e         m_fu     [NrEntries];
  reg_addr_t   m_rd     [NrEntries];
  xlen_t       m_result [NrEntries];
  int unsigned m_issue_ptr, m_commit_ptr, m_cnt;
  // full flushes applied to the model
  int unsigned nr_flush;

  scoreboard_top #(
    .NrEntries ( NrEntries ),
    .NrWbPorts ( NrWbPorts )
  ) i_scoreboard_top (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic stop_with_fail(string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] act);
    stop_with_fail($sformatf("FAILED at %0t ns: %s expected %0h actual %0h",
                             $time, name, exp, act));
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) report_mismatch(name, exp, act);
  endtask

  task automatic check_id(string name, id_t exp, id_t act);
    if (act !== exp) report_mismatch(name, exp, act);
  endtask

  task automatic check_reg(string name, reg_addr_t exp, reg_addr_t act);
    if (act !== exp) report_mismatch(name, exp, act);
  endtask

  task automatic check_fu(string name, fu_e exp, fu_e act);
    if (act !== exp) report_mismatch(name, exp, act);
  endtask

  task automatic check_data(string name, xlen_t exp, xlen_t act);
    if (act !== exp) report_mismatch(name, exp, act);
  endtask

  // write-back ports before done slots, lowest index first
  function automatic void model_forward(input reg_addr_t addr, output xlen_t data,
                                        output logic vld);
    logic hit;
    hit  = 1'b0;
    data = '0;
    for (int k = 0; k < NrWbPorts; k++) begin
      if (!hit && wb_valid_i[k] && m_rd[wb_trans_id_i[k]] == addr) begin
        hit  = 1'b1;
        data = wb_data_i[k];
      end
    end
    for (int i = 0; i < NrEntries; i++) begin
      if (!hit && m_issued[i] && m_done[i] && m_rd[i] == addr) begin
        hit  = 1'b1;
        data = m_result[i];
      end
    end
    vld = hit && (addr != 0);
  endfunction

  // ----------------------------------------
  // model step on the rising edge
  // ----------------------------------------
  task automatic update_model();
    logic old_issued [NrEntries];
    fu_e  old_fu     [NrEntries];
    logic issue_en;
    old_issued = m_issued;
    old_fu     = m_fu;
    issue_en   = decoded_valid_i && issue_ack_i && m_cnt < NrEntries && !flush_unissued_i;
    if (issue_en) begin
      m_issued[m_issue_ptr] = 1'b1;
      m_done[m_issue_ptr]   = 1'b0;
      m_fu[m_issue_ptr]     = decoded_fu_i;
      m_rd[m_issue_ptr]     = decoded_rd_i;
      m_result[m_issue_ptr] = '0;
    end
    // FU_NONE slots finish on their own
    for (int i = 0; i < NrEntries; i++) begin
      if (old_issued[i] && old_fu[i] == FU_NONE) m_done[i] = 1'b1;
    end
    for (int k = 0; k < NrWbPorts; k++) begin
      if (wb_valid_i[k] && old_issued[wb_trans_id_i[k]]) begin
        m_done[wb_trans_id_i[k]]   = 1'b1;
        m_result[wb_trans_id_i[k]] = wb_data_i[k];
      end
    end
    if (commit_ack_i) begin
      m_issued[m_commit_ptr] = 1'b0;
      m_done[m_commit_ptr]   = 1'b0;
    end
    if (flush_i) begin
      for (int i = 0; i < NrEntries; i++) begin
        m_issued[i] = 1'b0;
        m_done[i]   = 1'b0;
      end
      m_issue_ptr  = 0;
      m_commit_ptr = 0;
      m_cnt        = 0;
      nr_flush++;
    end else begin
      m_issue_ptr  = (m_issue_ptr + issue_en) % NrEntries;
      m_commit_ptr = (m_commit_ptr + commit_ack_i) % NrEntries;
      m_cnt        = m_cnt + issue_en - commit_ack_i;
    end
  endtask

  // legal inputs for the model state just reached
  task automatic drive_inputs(int unsigned commit_pct, logic allow_issue, logic allow_flush);
    logic                  dv;
    logic                  br;
    int unsigned           cand [$];
    int unsigned           pick;
    logic [NrWbPorts-1:0]  wb_v;
    id_t [NrWbPorts-1:0]   wb_id;
    xlen_t [NrWbPorts-1:0] wb_d;
    dv = allow_issue && $urandom_range(0, 99) < 70;
    br = $urandom_range(0, 99) < 10;
    // slots still waiting for a unit
    for (int i = 0; i < NrEntries; i++) begin
      if (m_issued[i] && !m_done[i] && m_fu[i] != FU_NONE) cand.push_back(i);
    end
    for (int k = 0; k < NrWbPorts; k++) begin
      wb_v[k]  = 1'b0;
      wb_id[k] = id_t'($urandom);
      wb_d[k]  = $urandom;
      if (cand.size() > 0 && $urandom_range(0, 99) < 40) begin
        pick     = $urandom_range(0, cand.size() - 1);
        wb_v[k]  = 1'b1;
        wb_id[k] = id_t'(cand[pick]);
        // each slot gets at most one port
        cand.delete(pick);
      end
    end
    decoded_valid_i     <= dv;
    unresolved_branch_i <= br;
    issue_ack_i         <= dv && !br && m_cnt < NrEntries && $urandom_range(0, 99) < 80;
    decoded_fu_i        <= fu_e'($urandom_range(0, 5));
    // narrow register range so hazards show up often
    decoded_rd_i        <= reg_addr_t'($urandom_range(0, 7));
    flush_unissued_i    <= $urandom_range(0, 99) < 5;
    flush_i             <= allow_flush && $urandom_range(0, 99) < 2;
    wb_valid_i          <= wb_v;
    wb_trans_id_i       <= wb_id;
    wb_data_i           <= wb_d;
    commit_ack_i        <= m_issued[m_commit_ptr] && m_done[m_commit_ptr] &&
                           $urandom_range(0, 99) < commit_pct;
    rs1_i               <= reg_addr_t'($urandom_range(0, 7));
    rs2_i               <= reg_addr_t'($urandom_range(0, 7));
  endtask

  // ----------------------------------------
  // output compare on the falling edge
  // ----------------------------------------
  task automatic check_outputs();
    logic  full;
    logic  cv;
    logic  found;
    fu_e   exp_fu;
    xlen_t fwd_data;
    logic  fwd_vld;
    full = (m_cnt == NrEntries);
    cv   = m_issued[m_commit_ptr] && m_done[m_commit_ptr];
    check_bit("sb_full_o", full, sb_full_o);
    check_bit("issue_valid_o", decoded_valid_i && !unresolved_branch_i && !full, issue_valid_o);
    check_bit("decoded_ack_o", issue_ack_i && !full, decoded_ack_o);
    check_id("issue_trans_id_o", id_t'(m_issue_ptr), issue_trans_id_o);
    check_bit("commit_valid_o", cv, commit_valid_o);
    if (cv) begin
      check_fu("commit_fu_o", m_fu[m_commit_ptr], commit_fu_o);
      check_reg("commit_rd_o", m_rd[m_commit_ptr], commit_rd_o);
      check_data("commit_result_o", m_result[m_commit_ptr], commit_result_o);
      check_id("commit_trans_id_o", id_t'(m_commit_ptr), commit_trans_id_o);
    end
    // lowest issued slot writing the register wins
    // x0 never has a writer
    for (int r = 0; r < NR_REGS; r++) begin
      found  = 1'b0;
      exp_fu = FU_NONE;
      for (int i = 0; i < NrEntries; i++) begin
        if (!found && r != 0 && m_issued[i] && m_rd[i] == r) begin
          found  = 1'b1;
          exp_fu = m_fu[i];
        end
      end
      check_fu($sformatf("rd_clobber_o[%0d]", r), exp_fu, rd_clobber_o[r]);
    end
    model_forward(rs1_i, fwd_data, fwd_vld);
    check_bit("rs1_valid_o", fwd_vld, rs1_valid_o);
    check_data("rs1_o", fwd_data, rs1_o);
    model_forward(rs2_i, fwd_data, fwd_vld);
    check_bit("rs2_valid_o", fwd_vld, rs2_valid_o);
    check_data("rs2_o", fwd_data, rs2_o);
  endtask

  task automatic run_cycle(int unsigned commit_pct, logic allow_issue, logic allow_flush);
    @(posedge clk_i);
    update_model();
    drive_inputs(commit_pct, allow_issue, allow_flush);
    @(negedge clk_i);
    check_outputs();
  endtask

  initial begin : stimulus
    int unsigned waited;
    void'($urandom(74187));
    rst_ni              = 1'b0;
    flush_i             = 1'b0;
    flush_unissued_i    = 1'b0;
    unresolved_branch_i = 1'b0;
    decoded_valid_i     = 1'b0;
    decoded_fu_i        = FU_NONE;
    decoded_rd_i        = '0;
    issue_ack_i         = 1'b0;
    wb_valid_i          = '0;
    wb_trans_id_i       = '0;
    wb_data_i           = '0;
    commit_ack_i        = 1'b0;
    rs1_i               = '0;
    rs2_i               = '0;
    for (int i = 0; i < NrEntries; i++) begin
      m_issued[i] = 1'b0;
      m_done[i]   = 1'b0;
      m_fu[i]     = FU_NONE;
      m_rd[i]     = '0;
      m_result[i] = '0;
    end
    m_issue_ptr  = 0;
    m_commit_ptr = 0;
    m_cnt        = 0;
    nr_flush     = 0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    // mixed traffic with both flush kinds
    repeat (2000) run_cycle(60, 1'b1, 1'b1);

    // hold commit back until every slot is taken
    waited = 0;
    while (m_cnt != NrEntries) begin
      if (waited == 200) begin
        stop_with_fail("table never filled up while commit was held back");
      end else begin
        run_cycle(0, 1'b1, 1'b0);
        waited++;
      end
    end
    repeat (4) run_cycle(0, 1'b1, 1'b0);

    // commits free slots of the full table while decode keeps offering
    repeat (40) run_cycle(100, 1'b1, 1'b0);

    // stop issuing and retire everything left
    waited = 0;
    while (m_cnt != 0) begin
      if (waited == 300) begin
        stop_with_fail("table did not drain after issue was stopped");
      end else begin
        run_cycle(100, 1'b0, 1'b0);
        waited++;
      end
    end

    if (nr_flush > 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_with_fail("no full flush was applied during the random traffic");
    end
  end

endmodule

// ==== files.f ====
design/sb_pkg.sv
design/sb_entry_table.sv
design/sb_clobber_map.sv
design/sb_operand_forward.sv
design/scoreboard_top.sv
verification/scoreboard_checker.sv
verification/tb_scoreboard.sv

// ==== Bender.yml ====
package:
  name: scoreboard

sources:
  - files:
      - design/sb_pkg.sv
      - design/sb_entry_table.sv
      - design/sb_clobber_map.sv
      - design/sb_operand_forward.sv
      - design/scoreboard_top.sv
  - target: test
    files:
      - verification/scoreboard_checker.sv
      - verification/tb_scoreboard.sv
